// File: design/ip_header_checksum.sv
`default_nettype none
`timescale 1ns/1ps

// IPv4 header checksum
// sums the ten header words with the checksum field taken as zero,
// folds the carries back in and registers the ones' complement
module ip_header_checksum
    import udp_tx_pkg::*;
#(
    parameter int PAYLOAD_LEN = 18
) (
    input  var logic        udp_sys_clk,
    input  var logic        rst_n,
    input  var udp_tx_cfg_t cfg,
    input  var logic [15:0] ip_id,
    output logic [15:0]     ip_checksum
);

    // total length covers IP header, UDP header and payload
    localparam logic [15:0] IP_TOTAL_LEN = 16'(IP_HDR_BYTES + UDP_HDR_BYTES + PAYLOAD_LEN);

    logic [15:0] hdr_word [10];
    logic [19:0] word_sum;
    logic [16:0] fold_1;
    logic [15:0] fold_2;

    always_comb begin
        hdr_word[0] = {IP_VER_IHL, cfg.dscp, cfg.ecn};
        hdr_word[1] = IP_TOTAL_LEN;
        hdr_word[2] = ip_id;
        hdr_word[3] = IP_FLAGS_DF;
        hdr_word[4] = {cfg.ttl, IP_PROTO_UDP};
        // checksum field itself counts as zero
        hdr_word[5] = 16'h0000;
        hdr_word[6] = cfg.src_ip[31:16];
        hdr_word[7] = cfg.src_ip[15:0];
        hdr_word[8] = cfg.dst_ip[31:16];
        hdr_word[9] = cfg.dst_ip[15:0];
        // 20 bits holds ten 16-bit words without overflow
        word_sum = 20'd0;
        for (int i = 0; i < 10; i++) begin
            word_sum = word_sum + 20'(hdr_word[i]);
        end
        // two folds are enough to absorb every carry
        fold_1 = 17'(word_sum[15:0]) + 17'(word_sum[19:16]);
        fold_2 = fold_1[15:0] + 16'(fold_1[16]);
    end

    // settles one cycle after cfg or ip_id moves
    always_ff @(posedge udp_sys_clk) begin
        if (!rst_n) begin
            ip_checksum <= 16'h0000;
        end else begin
            ip_checksum <= ~fold_2;
        end
    end

endmodule

`default_nettype wire

// File: design/mii_tx_mac.sv
`default_nettype none
`timescale 1ns/1ps

// MII transmit MAC
// preamble + SFD, nibble serializer, CRC-32 trailer and inter-frame gap
// one nibble per clock, low nibble of each byte first
module mii_tx_mac
    import udp_tx_pkg::*;
(
    input  var logic     udp_sys_clk,
    input  var logic     rst_n,
    input  var logic     frame_start,
    input  var logic     byte_strobe,
    input  var tx_byte_t tx_byte,
    output logic         byte_req,
    output logic         mac_idle,
    output logic [3:0]   mii_txd,
    output logic         mii_tx_en
);

    // preamble and SFD together, counted in nibbles
    localparam logic [4:0] PRE_LAST = 5'd15;
    localparam logic [4:0] FCS_LAST = 5'd7;
    localparam logic [4:0] GAP_LAST = 5'(2 * IFG_BYTES - 1);

    mac_state_e  state;
    // nibble counter, bit 0 doubles as the high-nibble flag in ms_data
    logic [4:0]  cnt;
    tx_byte_t    cur_byte;
    logic [31:0] crc;
    logic [31:0] fcs_val;
    logic [7:0]  pre_byte;

    // one byte through the reflected CRC-32, bit at a time
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input logic [7:0] data);
        logic [31:0] c;
        c = crc_in ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC32_POLY) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge udp_sys_clk) begin
        if (!rst_n) begin
            state <= ms_idle;
            cnt   <= 5'd0;
        end else begin
            case (state)
                ms_idle: begin
                    if (frame_start) begin
                        state <= ms_preamble;
                        cnt   <= 5'd0;
                    end
                end
                ms_preamble: begin
                    if (cnt == PRE_LAST) begin
                        state <= ms_data;
                        cnt   <= 5'd0;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                ms_data: begin
                    cnt <= cnt[0] ? 5'd0 : 5'd1;
                    // end of frame is taken from the byte itself
                    if (cnt[0] && cur_byte.last) begin
                        state <= ms_fcs;
                    end
                end
                ms_fcs: begin
                    if (cnt == FCS_LAST) begin
                        state <= ms_gap;
                        cnt   <= 5'd0;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                default: begin
                    // ms_gap, tx_en held low for the full IFG
                    if (cnt == GAP_LAST) begin
                        state <= ms_idle;
                        cnt   <= 5'd0;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
            endcase
        end
    end

    // byte and CRC registers
    always_ff @(posedge udp_sys_clk) begin
        // strobe lands on the high-nibble cycle of the byte before
        if (byte_strobe) begin
            cur_byte <= tx_byte;
        end
        // first byte restarts the CRC from all ones
        if (state == ms_data && cnt[0]) begin
            crc <= crc32_byte(cur_byte.first ? 32'hFFFF_FFFF : crc, cur_byte.data);
        end
    end

    // ask on the low nibble so the answer arrives on the high nibble
    assign byte_req = (state == ms_preamble && cnt == PRE_LAST - 5'd1)
                   || (state == ms_data && !cnt[0] && !cur_byte.last);
    assign mac_idle = (state == ms_idle);

    // FCS goes out complemented, least significant byte first
    assign fcs_val  = ~crc;
    // seven 0x55 then the SFD
    assign pre_byte = (cnt[3:1] == 3'd7) ? 8'hD5 : 8'h55;

    always_comb begin
        mii_tx_en = 1'b0;
        mii_txd   = 4'h0;
        case (state)
            ms_preamble: begin
                mii_tx_en = 1'b1;
                mii_txd   = cnt[0] ? pre_byte[7:4] : pre_byte[3:0];
            end
            ms_data: begin
                mii_tx_en = 1'b1;
                mii_txd   = cnt[0] ? cur_byte.data[7:4] : cur_byte.data[3:0];
            end
            ms_fcs: begin
                mii_tx_en = 1'b1;
                mii_txd   = fcs_val[4*cnt[2:0] +: 4];
            end
            default: begin
                mii_tx_en = 1'b0;
                mii_txd   = 4'h0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/payload_counter_source.sv
`default_nettype none
`timescale 1ns/1ps

// incrementing payload source
// the value only moves when the builder consumes a byte, so the
// byte stream seen by the receiver has no holes, even across frames
module payload_counter_source (
    input  var logic       udp_sys_clk,
    input  var logic       rst_n,
    // one pulse per payload byte placed into a frame
    input  var logic       payload_take,
    // byte offered for the next payload position
    output logic [7:0]     payload_byte
);

    logic [7:0] count;

    // counter starts at zero after reset
    // wraps 255 -> 0 through natural 8-bit overflow
    always_ff @(posedge udp_sys_clk) begin
        if (!rst_n) begin
            count <= 8'd0;
        end else if (payload_take) begin
            // advance after the current value has been sampled
            count <= count + 8'd1;
        end
    end

    // the builder samples this one cycle before the take pulse
    assign payload_byte = count;

endmodule

`default_nettype wire

// File: design/udp_frame_builder.sv
`default_nettype none
`timescale 1ns/1ps

// frame composer
// starts a frame when enabled and the MAC is free, then answers each
// byte request one cycle later with the next header or payload byte
module udp_frame_builder
    import udp_tx_pkg::*;
#(
    parameter int PAYLOAD_LEN = 18
) (
    input  var logic        udp_sys_clk,
    input  var logic        rst_n,
    input  var logic        tx_enable,
    input  var udp_tx_cfg_t cfg,
    input  var logic        mac_idle,
    input  var logic        byte_req,
    input  var logic [15:0] ip_checksum,
    input  var logic [7:0]  payload_byte,
    output logic            frame_start,
    output logic            byte_strobe,
    output tx_byte_t        tx_byte,
    output logic            payload_take,
    output logic [15:0]     ip_id,
    output logic [15:0]     frame_count
);

    localparam logic [15:0] UDP_LEN      = 16'(UDP_HDR_BYTES + PAYLOAD_LEN);
    localparam logic [15:0] IP_TOTAL_LEN = 16'(IP_HDR_BYTES + UDP_HDR_BYTES + PAYLOAD_LEN);

    frame_state_e state;
    logic [15:0]  byte_idx;
    // frame handed over, waiting for the MAC to drain it
    logic         frame_pending;

    logic [8*ETH_HDR_BYTES-1:0] eth_hdr;
    logic [8*IP_HDR_BYTES-1:0]  ip_hdr;
    logic [8*UDP_HDR_BYTES-1:0] udp_hdr;
    tx_byte_t                   sel_byte;
    logic                       sec_end;

    // headers as flat big-endian vectors, byte 0 in the top bits
    assign eth_hdr = {cfg.dst_mac, cfg.src_mac, ETHERTYPE_IPV4};
    assign ip_hdr  = {IP_VER_IHL, cfg.dscp, cfg.ecn, IP_TOTAL_LEN, ip_id, IP_FLAGS_DF,
                      cfg.ttl, IP_PROTO_UDP, ip_checksum, cfg.src_ip, cfg.dst_ip};
    // UDP checksum left at zero, which means not computed
    assign udp_hdr = {cfg.src_port, cfg.dst_port, UDP_LEN, 16'h0000};

    // pick the byte for the current position and flag the section end
    always_comb begin
        sel_byte = '0;
        sec_end  = 1'b0;
        case (state)
            st_eth_hdr: begin
                sel_byte.data  = eth_hdr[8*(ETH_HDR_BYTES-1-int'(byte_idx)) +: 8];
                sel_byte.first = (byte_idx == 16'd0);
                sec_end        = (byte_idx == 16'(ETH_HDR_BYTES - 1));
            end
            st_ip_hdr: begin
                // checksum bytes come 24 bytes after the start, long settled
                sel_byte.data = ip_hdr[8*(IP_HDR_BYTES-1-int'(byte_idx)) +: 8];
                sec_end       = (byte_idx == 16'(IP_HDR_BYTES - 1));
            end
            st_udp_hdr: begin
                sel_byte.data = udp_hdr[8*(UDP_HDR_BYTES-1-int'(byte_idx)) +: 8];
                sec_end       = (byte_idx == 16'(UDP_HDR_BYTES - 1));
            end
            st_payload: begin
                sel_byte.data = payload_byte;
                sec_end       = (byte_idx == 16'(PAYLOAD_LEN - 1));
                sel_byte.last = sec_end;
            end
            default: begin
                sel_byte = '0;
            end
        endcase
    end

    // sequencing, strobes and frame bookkeeping
    always_ff @(posedge udp_sys_clk) begin
        if (!rst_n) begin
            state         <= st_idle;
            byte_idx      <= 16'd0;
            frame_start   <= 1'b0;
            byte_strobe   <= 1'b0;
            payload_take  <= 1'b0;
            frame_pending <= 1'b0;
            ip_id         <= 16'd0;
            frame_count   <= 16'd0;
        end else begin
            // pulses default low
            frame_start  <= 1'b0;
            byte_strobe  <= 1'b0;
            payload_take <= 1'b0;
            // MAC back in idle means FCS and gap are done
            if (frame_pending && mac_idle) begin
                frame_pending <= 1'b0;
                frame_count   <= frame_count + 16'd1;
            end
            case (state)
                st_idle: begin
                    if (tx_enable && mac_idle) begin
                        frame_start <= 1'b1;
                        byte_idx    <= 16'd0;
                        state       <= st_eth_hdr;
                    end
                end
                default: begin
                    if (byte_req) begin
                        byte_strobe  <= 1'b1;
                        payload_take <= (state == st_payload);
                        if (sec_end) begin
                            byte_idx <= 16'd0;
                            case (state)
                                st_eth_hdr: state <= st_ip_hdr;
                                st_ip_hdr:  state <= st_udp_hdr;
                                st_udp_hdr: state <= st_payload;
                                default: begin
                                    // last payload byte, frame fully handed over
                                    state         <= st_idle;
                                    ip_id         <= ip_id + 16'd1;
                                    frame_pending <= 1'b1;
                                end
                            endcase
                        end else begin
                            byte_idx <= byte_idx + 16'd1;
                        end
                    end
                end
            endcase
        end
    end

    // byte register, only meaningful with byte_strobe
    always_ff @(posedge udp_sys_clk) begin
        if (byte_req) begin
            tx_byte <= sel_byte;
        end
    end

endmodule

`default_nettype wire

// File: design/udp_tx_pkg.sv
`default_nettype none

package udp_tx_pkg;

    // static configuration of the sender, held constant while frames go out
    typedef struct packed {
        logic [47:0] src_mac;
        logic [47:0] dst_mac;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [7:0]  ttl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        // spare bits, rounds the struct out to 216
        logic [7:0]  pad;
    } udp_tx_cfg_t;

    // one frame byte handed from the builder to the MAC
    typedef struct packed {
        logic [7:0] data;
        // destination MAC byte 0
        logic       first;
        // final payload byte
        logic       last;
    } tx_byte_t;

    typedef enum logic [2:0] {
        st_idle,
        st_eth_hdr,
        st_ip_hdr,
        st_udp_hdr,
        st_payload
    } frame_state_e;

    typedef enum logic [2:0] {
        ms_idle,
        ms_preamble,
        ms_data,
        ms_fcs,
        ms_gap
    } mac_state_e;

    // header sizes in bytes
    localparam int ETH_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    // version 4, five 32-bit header words
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    // flags word with don't fragment set, offset zero
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;

    // inter-frame gap, in bytes on the wire
    localparam int IFG_BYTES = 12;

    // reflected ethernet polynomial
    localparam logic [31:0] CRC32_POLY = 32'hEDB88320;

endpackage

`default_nettype wire

// File: design/udp_tx_top.sv
`default_nettype none
`timescale 1ns/1ps

// transmit-only UDP sender on an MII PHY
// counter payload, fixed headers from cfg, frames back to back while enabled
module udp_tx_top
    import udp_tx_pkg::*;
#(
    // at least 18 so the frame never needs padding
    parameter int PAYLOAD_LEN = 18
) (
    input  var logic        udp_sys_clk,
    input  var logic        rst_n,
    input  var logic        tx_enable,
    input  var udp_tx_cfg_t cfg,
    output logic [3:0]      mii_txd,
    output logic            mii_tx_en,
    output logic [15:0]     frame_count
);

    // builder <-> MAC
    logic        frame_start;
    logic        byte_req;
    logic        byte_strobe;
    logic        mac_idle;
    tx_byte_t    tx_byte;
    // builder <-> payload source and checksum
    logic        payload_take;
    logic [7:0]  payload_byte;
    logic [15:0] ip_id;
    logic [15:0] ip_checksum;

    payload_counter_source u_payload_source (
        .udp_sys_clk (udp_sys_clk),
        .rst_n       (rst_n),
        .payload_take(payload_take),
        .payload_byte(payload_byte)
    );

    ip_header_checksum #(
        .PAYLOAD_LEN(PAYLOAD_LEN)
    ) u_ip_checksum (
        .udp_sys_clk(udp_sys_clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .ip_id      (ip_id),
        .ip_checksum(ip_checksum)
    );

    udp_frame_builder #(
        .PAYLOAD_LEN(PAYLOAD_LEN)
    ) u_frame_builder (
        .udp_sys_clk (udp_sys_clk),
        .rst_n       (rst_n),
        .tx_enable   (tx_enable),
        .cfg         (cfg),
        .mac_idle    (mac_idle),
        .byte_req    (byte_req),
        .ip_checksum (ip_checksum),
        .payload_byte(payload_byte),
        .frame_start (frame_start),
        .byte_strobe (byte_strobe),
        .tx_byte     (tx_byte),
        .payload_take(payload_take),
        .ip_id       (ip_id),
        .frame_count (frame_count)
    );

    mii_tx_mac u_mii_mac (
        .udp_sys_clk(udp_sys_clk),
        .rst_n      (rst_n),
        .frame_start(frame_start),
        .byte_strobe(byte_strobe),
        .tx_byte    (tx_byte),
        .byte_req   (byte_req),
        .mac_idle   (mac_idle),
        .mii_txd    (mii_txd),
        .mii_tx_en  (mii_tx_en)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the UDP sender testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module udp_tx_tb -o udp_tx_sim

# the simulator status alone does not decide the result
out=$(./obj_dir/udp_tx_sim) || true
echo "$out"

echo "$out" | grep -q "TEST PASSED"

// File: sim.f
design/udp_tx_pkg.sv
design/payload_counter_source.sv
design/ip_header_checksum.sv
design/udp_frame_builder.sv
design/mii_tx_mac.sv
design/udp_tx_top.sv
test/udp_tx_checker.sv
test/udp_tx_tb.sv

// File: test/udp_tx_checker.sv
`default_nettype none
`timescale 1ns/1ps

// protocol checks on the MAC side of the sender
module udp_tx_checker (
    input var logic       udp_sys_clk,
    input var logic       rst_n,
    input var logic       byte_req,
    input var logic       byte_strobe,
    input var logic [3:0] mii_txd,
    input var logic       mii_tx_en
);

    // PHY sees no transmit while held in reset
    assert property (@(posedge udp_sys_clk) !rst_n |-> !mii_tx_en)
        else $error("mii_tx_en high during reset");

    // builder answers every request exactly one cycle later
    assert property (@(posedge udp_sys_clk) disable iff (!rst_n)
        byte_req |=> byte_strobe)
        else $error("byte_req not answered by byte_strobe");

    // no X nibbles on the wire
    assert property (@(posedge udp_sys_clk) disable iff (!rst_n)
        mii_tx_en |-> !$isunknown(mii_txd))
        else $error("mii_txd unknown while mii_tx_en high");

endmodule

bind mii_tx_mac udp_tx_checker u_checker (
    .udp_sys_clk(udp_sys_clk),
    .rst_n      (rst_n),
    .byte_req   (byte_req),
    .byte_strobe(byte_strobe),
    .mii_txd    (mii_txd),
    .mii_tx_en  (mii_tx_en)
);

`default_nettype wire

// File: test/udp_tx_tb.sv
`default_nettype none
`timescale 1ns/1ps

module udp_tx_tb import udp_tx_pkg::*; ();

    localparam int PAYLOAD_LEN  = 18;
    // preamble + headers + payload + FCS
    localparam int FRAME_BYTES  = 8 + 42 + PAYLOAD_LEN + 4;
    localparam int MAX_FRAMES   = 32;
    localparam int TOTAL_FRAMES = 19;
    localparam int WATCHDOG_CYC = TOTAL_FRAMES * 170 + 3000;

    logic        udp_sys_clk = 1'b0;
    logic        rst_n;
    logic        tx_enable;
    udp_tx_cfg_t cfg;
    logic [3:0]  mii_txd;
    logic        mii_tx_en;
    logic [15:0] frame_count;

    // capture store, one row per frame seen on the MII
    logic [7:0] frame_mem [MAX_FRAMES][FRAME_BYTES];
    int         frame_cyc [MAX_FRAMES];
    int         frame_gap [MAX_FRAMES];
    int         frames_captured = 0;
    int         nib_cnt = 0;
    int         idle_cnt = 0;
    bit         in_frame = 1'b0;
    logic [3:0] low_nib;

    // reference model state, runs alongside the DUT from reset
    logic [7:0]  exp_frame [FRAME_BYTES];
    int          model_id = 0;
    int          model_pay = 0;
    logic [31:0] lcg_state = 32'h7d59;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #20 udp_sys_clk = ~udp_sys_clk;

    udp_tx_top #(
        .PAYLOAD_LEN(PAYLOAD_LEN)
    ) u_dut (
        .udp_sys_clk(udp_sys_clk),
        .rst_n      (rst_n),
        .tx_enable  (tx_enable),
        .cfg        (cfg),
        .mii_txd    (mii_txd),
        .mii_tx_en  (mii_tx_en),
        .frame_count(frame_count)
    );

    // nibbles to bytes, low nibble arrives first
    always @(posedge udp_sys_clk) begin
        if (!rst_n) begin
            in_frame = 1'b0;
            idle_cnt = 0;
        end else if (mii_tx_en) begin
            if (!in_frame) begin
                in_frame = 1'b1;
                nib_cnt  = 0;
                frame_gap[frames_captured] = idle_cnt;
            end
            if (nib_cnt[0] == 1'b0) begin
                low_nib = mii_txd;
            end else if (nib_cnt / 2 < FRAME_BYTES) begin
                frame_mem[frames_captured][nib_cnt / 2] = {mii_txd, low_nib};
            end
            nib_cnt++;
        end else begin
            if (in_frame) begin
                frame_cyc[frames_captured] = nib_cnt;
                if (frames_captured < MAX_FRAMES - 1) begin
                    frames_captured++;
                end
                in_frame = 1'b0;
                idle_cnt = 0;
            end
            idle_cnt++;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_min(input string name, input int got, input int lim);
        assert (got >= lim) else begin
            $display("CHECK FAILED at %0t: %s got %0d expected at least %0d",
                     $time, name, got, lim);
            error_count++;
        end
    endtask

    function automatic string byte_name(input int i);
        if (i < 8) return $sformatf("preamble[%0d]", i);
        if (i < 14) return $sformatf("dst_mac[%0d]", i - 8);
        if (i < 20) return $sformatf("src_mac[%0d]", i - 14);
        if (i < 22) return $sformatf("ethertype[%0d]", i - 20);
        if (i < 42) return $sformatf("ip_hdr[%0d]", i - 22);
        if (i < 50) return $sformatf("udp_hdr[%0d]", i - 42);
        if (i < 50 + PAYLOAD_LEN) return $sformatf("payload[%0d]", i - 50);
        return $sformatf("fcs[%0d]", i - 50 - PAYLOAD_LEN);
    endfunction

    // expected wire bytes for the next frame, straight from the header layouts
    task automatic build_expected();
        logic [7:0]  hdr [20];
        logic [31:0] sum;
        logic [15:0] csum;
        logic [31:0] crc;
        for (int i = 0; i < 7; i++) exp_frame[i] = 8'h55;
        exp_frame[7] = 8'hD5;
        for (int i = 0; i < 6; i++) begin
            exp_frame[8 + i]  = cfg.dst_mac[47 - 8 * i -: 8];
            exp_frame[14 + i] = cfg.src_mac[47 - 8 * i -: 8];
        end
        exp_frame[20] = 8'h08;
        exp_frame[21] = 8'h00;
        hdr[0]  = 8'h45;
        hdr[1]  = {cfg.dscp, cfg.ecn};
        hdr[2]  = 8'h00;
        hdr[3]  = 8'(28 + PAYLOAD_LEN);
        hdr[4]  = 8'(model_id >> 8);
        hdr[5]  = 8'(model_id);
        // don't fragment
        hdr[6]  = 8'h40;
        hdr[7]  = 8'h00;
        hdr[8]  = cfg.ttl;
        hdr[9]  = 8'd17;
        hdr[10] = 8'h00;
        hdr[11] = 8'h00;
        for (int i = 0; i < 4; i++) begin
            hdr[12 + i] = cfg.src_ip[31 - 8 * i -: 8];
            hdr[16 + i] = cfg.dst_ip[31 - 8 * i -: 8];
        end
        sum = 32'd0;
        for (int i = 0; i < 10; i++) sum = sum + 32'({hdr[2 * i], hdr[2 * i + 1]});
        while (sum[31:16] != 16'd0) sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        csum    = ~sum[15:0];
        hdr[10] = csum[15:8];
        hdr[11] = csum[7:0];
        for (int i = 0; i < 20; i++) exp_frame[22 + i] = hdr[i];
        exp_frame[42] = cfg.src_port[15:8];
        exp_frame[43] = cfg.src_port[7:0];
        exp_frame[44] = cfg.dst_port[15:8];
        exp_frame[45] = cfg.dst_port[7:0];
        exp_frame[46] = 8'h00;
        exp_frame[47] = 8'(8 + PAYLOAD_LEN);
        exp_frame[48] = 8'h00;
        exp_frame[49] = 8'h00;
        for (int i = 0; i < PAYLOAD_LEN; i++) exp_frame[50 + i] = 8'(model_pay + i);
        // reflected CRC-32, data bits taken lsb first
        crc = 32'hFFFF_FFFF;
        for (int p = 8; p < 50 + PAYLOAD_LEN; p++) begin
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ exp_frame[p][b]) crc = (crc >> 1) ^ 32'hEDB88320;
                else crc = crc >> 1;
            end
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) exp_frame[50 + PAYLOAD_LEN + i] = crc[8 * i +: 8];
    endtask

    // compare one captured frame with the model, then step the model
    task automatic check_frame(input int f);
        build_expected();
        for (int i = 0; i < FRAME_BYTES; i++) begin
            check_val(byte_name(i), int'(frame_mem[f][i]), int'(exp_frame[i]));
        end
        check_val("mii_tx_en cycles", frame_cyc[f], 2 * FRAME_BYTES);
        model_id  = model_id + 1;
        model_pay = (model_pay + PAYLOAD_LEN) % 256;
    endtask

    task automatic random_cfg();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        r0 = lcg_next();
        r1 = lcg_next();
        r2 = lcg_next();
        r3 = lcg_next();
        r4 = lcg_next();
        r5 = lcg_next();
        @(posedge udp_sys_clk);
        cfg <= '{src_mac: {r0[15:0], r1}, dst_mac: {r1[31:16], r2}, src_ip: r3, dst_ip: r4,
                 src_port: r5[15:0], dst_port: r5[31:16], ttl: r0[23:16],
                 dscp: r0[29:24], ecn: r0[31:30], pad: 8'h00};
    endtask

    // enable until n more frames are on the wire, then wait for frame_count
    task automatic run_frames(input int n);
        int target;
        target = frames_captured + n;
        @(posedge udp_sys_clk);
        tx_enable <= 1'b1;
        while (frames_captured < target) @(posedge udp_sys_clk);
        // still inside the gap, so no further frame starts
        tx_enable <= 1'b0;
        while (int'(frame_count) != frames_captured) @(posedge udp_sys_clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic test_reset_idle();
        int e0;
        e0 = error_count;
        repeat (200) begin
            @(posedge udp_sys_clk);
            check_val("mii_tx_en", int'(mii_tx_en), 0);
            check_val("frame_count", int'(frame_count), 0);
        end
        report_test("reset and idle", e0);
    endtask

    task automatic test_frame_layout();
        int e0;
        int f;
        e0 = error_count;
        @(posedge udp_sys_clk);
        cfg <= '{src_mac: 48'h02_00_00_00_00_01, dst_mac: 48'h02_00_00_00_00_02,
                 src_ip: 32'hC0A8_0101, dst_ip: 32'hC0A8_0102, src_port: 16'd5000,
                 dst_port: 16'd6000, ttl: 8'd64, dscp: 6'd0, ecn: 2'd0, pad: 8'h00};
        f = frames_captured;
        run_frames(1);
        check_frame(f);
        report_test("frame layout", e0);
    endtask

    task automatic test_checksum_id();
        int e0;
        int f;
        logic [31:0] sum;
        e0 = error_count;
        for (int k = 0; k < 4; k++) begin
            random_cfg();
            f = frames_captured;
            run_frames(1);
            check_val("ip_id", int'({frame_mem[f][26], frame_mem[f][27]}), model_id);
            sum = 32'd0;
            for (int i = 0; i < 10; i++) begin
                sum = sum + 32'({frame_mem[f][22 + 2 * i], frame_mem[f][23 + 2 * i]});
            end
            while (sum[31:16] != 16'd0) sum = 32'(sum[15:0]) + 32'(sum[31:16]);
            check_val("ip header sum", int'(sum), 32'hFFFF);
            check_frame(f);
        end
        report_test("ip checksum and id", e0);
    endtask

    task automatic test_payload_continuity();
        int e0;
        int f;
        e0 = error_count;
        f = frames_captured;
        run_frames(10);
        for (int k = 0; k < 10; k++) begin
            // first byte continues from the previous frame's last byte
            check_val("payload start", int'(frame_mem[f + k][50]), model_pay);
            check_frame(f + k);
        end
        report_test("payload continuity", e0);
    endtask

    task automatic test_fcs_gap();
        int e0;
        int f;
        e0 = error_count;
        f = frames_captured;
        run_frames(3);
        for (int k = 0; k < 3; k++) begin
            check_frame(f + k);
            if (k > 0) check_min("mii_tx_en low gap", frame_gap[f + k], 2 * IFG_BYTES);
        end
        report_test("fcs and gap", e0);
    endtask

    task automatic test_enable_drop();
        int e0;
        int f;
        e0 = error_count;
        f = frames_captured;
        @(posedge udp_sys_clk);
        tx_enable <= 1'b1;
        while (!in_frame) @(posedge udp_sys_clk);
        // drop in the middle of the data phase
        repeat (40) @(posedge udp_sys_clk);
        tx_enable <= 1'b0;
        while (frames_captured == f) @(posedge udp_sys_clk);
        repeat (300) @(posedge udp_sys_clk);
        check_val("frames captured", frames_captured, f + 1);
        check_val("frame_count", int'(frame_count), frames_captured);
        check_frame(f);
        report_test("enable drop", e0);
    endtask

    // a hung handshake never reaches the summary
    initial begin
        repeat (WATCHDOG_CYC) @(posedge udp_sys_clk);
        $display("watchdog expired, the DUT stopped producing frames");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        tx_enable = 1'b0;
        cfg       = '0;
        repeat (3) @(posedge udp_sys_clk);
        rst_n <= 1'b1;
        test_reset_idle();
        test_frame_layout();
        test_checksum_id();
        test_payload_continuity();
        test_fcs_gap();
        test_enable_drop();
        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
